/* Bender.yml */
package:
  name: inst_track

sources:
  # design, package first
  - logic/inst_track_pkg.sv
  - logic/lookup_cache.sv
  - logic/result_shiftreg.sv
  - logic/reg_track.sv
  - logic/inst_track.sv
  # testbench
  - target: test
    files:
      - verif/inst_track_checker.sv
      - verif/tb_inst_track.sv

/* logic/inst_track.sv */
// issue-stage dependency tracker for an in-order core
// GPR and CTR trackers combined into one ready and one pipe-empty flag

module inst_track (
  input  logic                                         clk,
  input  logic                                         rst_i,
  // instruction at issue
  input  logic                                         issue_i,
  input  inst_track_pkg::latency_t                     latency_i,
  input  inst_track_pkg::fu_set_t                      fu_i,
  input  logic                                         disable_wb_i,
  // gpr operands, read enables are bit 0 ra, bit 1 rb, bit 2 rt
  input  logic                                         gpr_write_i,
  input  inst_track_pkg::gpr_idx_t                     gpr_dest_i,
  input  logic [inst_track_pkg::GPR_NUM_READ_PORTS-1:0] gpr_read_i,
  input  inst_track_pkg::gpr_idx_t                     gpr_ra_i,
  input  inst_track_pkg::gpr_idx_t                     gpr_rb_i,
  input  inst_track_pkg::gpr_idx_t                     gpr_rt_i,
  // ctr operands
  input  logic                                         ctr_write_i,
  input  logic                                         ctr_read_i,
  // issue handshake and global status
  output logic                                         ready_o,
  output logic                                         pipe_empty_o,
  // gpr write-back
  output logic                                         gpr_wb_we_o,
  output inst_track_pkg::gpr_idx_t                     gpr_wb_dest_o,
  output inst_track_pkg::fu_set_t                      gpr_wb_src_o,
  // ctr write-back
  output logic                                         ctr_wb_we_o,
  output inst_track_pkg::fu_set_t                      ctr_wb_src_o
);

  import inst_track_pkg::*;

  gpr_idx_t gpr_read_addr [GPR_NUM_READ_PORTS];
  logic     gpr_ready;
  logic     gpr_empty;
  // ctr is a single register, address always 0
  logic [0:0] ctr_read_addr [1];
  logic       ctr_ready;
  logic       ctr_empty;

  // --------------------------------------
  // gpr tracker
  // --------------------------------------

  assign gpr_read_addr[0] = gpr_ra_i;
  assign gpr_read_addr[1] = gpr_rb_i;
  assign gpr_read_addr[2] = gpr_rt_i;

  reg_track #(
    .DEST_W        ($bits(gpr_idx_t)),
    .NUM_STAGES    (GPR_NUM_STAGES),
    .NUM_READ_PORTS(GPR_NUM_READ_PORTS)
  ) u_gpr_track (
    .clk         (clk),
    .rst_i       (rst_i),
    .issue_i     (issue_i),
    .write_i     (gpr_write_i),
    .dest_i      (gpr_dest_i),
    .read_i      (gpr_read_i),
    .read_addr_i (gpr_read_addr),
    .latency_i   (latency_i),
    .fu_i        (fu_i),
    .disable_wb_i(disable_wb_i),
    .ready_o     (gpr_ready),
    .empty_o     (gpr_empty),
    .wb_we_o     (gpr_wb_we_o),
    .wb_dest_o   (gpr_wb_dest_o),
    .wb_src_o    (gpr_wb_src_o)
  );

  // --------------------------------------
  // ctr tracker
  // --------------------------------------

  assign ctr_read_addr[0] = 1'b0;

  // destination is fixed, so only the write-back enable and source leave
  reg_track #(
    .DEST_W        (1),
    .NUM_STAGES    (CTR_NUM_STAGES),
    .NUM_READ_PORTS(1)
  ) u_ctr_track (
    .clk         (clk),
    .rst_i       (rst_i),
    .issue_i     (issue_i),
    .write_i     (ctr_write_i),
    .dest_i      (1'b0),
    .read_i      (ctr_read_i),
    .read_addr_i (ctr_read_addr),
    .latency_i   (latency_i),
    .fu_i        (fu_i),
    .disable_wb_i(disable_wb_i),
    .ready_o     (ctr_ready),
    .empty_o     (ctr_empty),
    .wb_we_o     (ctr_wb_we_o),
    .wb_dest_o   (),
    .wb_src_o    (ctr_wb_src_o)
  );

  // issue only when every register class is free of hazards
  assign ready_o      = gpr_ready & ctr_ready;
  assign pipe_empty_o = gpr_empty & ctr_empty;

endmodule

/* logic/inst_track_pkg.sv */
// instruction tracker package
// widths, types and shift register depths shared by the GPR and CTR trackers

package inst_track_pkg;

  // --------------------------------------
  // sizes
  // --------------------------------------

  // number of general-purpose registers
  localparam int NUM_GPR = 32;

  // result shift register depths, also the max latency per class
  localparam int GPR_NUM_STAGES = 6;
  localparam int CTR_NUM_STAGES = 3;

  // source operands tested per instruction (ra, rb, rt)
  localparam int GPR_NUM_READ_PORTS = 3;

  // --------------------------------------
  // types
  // --------------------------------------

  // gpr index
  typedef logic [$clog2(NUM_GPR)-1:0] gpr_idx_t;
  // functional unit producing the result
  typedef logic [2:0] fu_set_t;
  // cycles from issue to write-back
  typedef logic [2:0] latency_t;

endpackage

/* logic/lookup_cache.sv */
// pending-write lookup cache
// one bit per destination register, set on issue and cleared at write-back

module lookup_cache #(
  parameter int SIZE           = 32,
  parameter int NUM_TEST_PORTS = 3
) (
  input  logic                      clk,
  input  logic                      rst_i,
  // set port, from an accepted write
  input  logic                      set_i,
  input  logic [$clog2(SIZE)-1:0]   set_addr_i,
  // clear port, from the shift register output stage
  input  logic                      clear_i,
  input  logic [$clog2(SIZE)-1:0]   clear_addr_i,
  // read operand tests
  input  logic [$clog2(SIZE)-1:0]   test_addr_i [NUM_TEST_PORTS],
  output logic [NUM_TEST_PORTS-1:0] found_o,
  // destination test on the set address
  output logic                      waw_found_o,
  output logic                      empty_o
);

  logic [SIZE-1:0] pending_q;
  logic [SIZE-1:0] pending_d;

  // --------------------------------------
  // pending vector update
  // --------------------------------------

  // clear first, so a set to the same address wins
  always_comb begin
    pending_d = pending_q;
    if (clear_i) begin
      pending_d[clear_addr_i] = 1'b0;
    end
    if (set_i) begin
      pending_d[set_addr_i] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  // --------------------------------------
  // combinational lookups
  // --------------------------------------

  // one lookup per read port, state before this cycle's update
  always_comb begin
    for (int p = 0; p < NUM_TEST_PORTS; p++) begin
      found_o[p] = pending_q[test_addr_i[p]];
    end
  end

  assign waw_found_o = pending_q[set_addr_i];

  // nothing pending at all
  assign empty_o = ~(|pending_q);

endmodule

/* logic/reg_track.sv */
// dependency tracker for one register class
// combines the result shift register and the lookup cache into ready,
// empty and the scheduled write-back

module reg_track #(
  parameter int DEST_W         = 5,
  parameter int NUM_STAGES     = 6,
  parameter int NUM_READ_PORTS = 3
) (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     issue_i,
  // destination of the instruction at issue
  input  logic                     write_i,
  input  logic [DEST_W-1:0]        dest_i,
  // source operands
  input  logic [NUM_READ_PORTS-1:0] read_i,
  input  logic [DEST_W-1:0]        read_addr_i [NUM_READ_PORTS],
  input  inst_track_pkg::latency_t latency_i,
  input  inst_track_pkg::fu_set_t  fu_i,
  input  logic                     disable_wb_i,
  output logic                     ready_o,
  output logic                     empty_o,
  // write-back channel
  output logic                     wb_we_o,
  output logic [DEST_W-1:0]        wb_dest_o,
  output inst_track_pkg::fu_set_t  wb_src_o
);

  import inst_track_pkg::*;

  logic                      accept;
  logic                      occupied;
  logic                      out_valid;
  logic [DEST_W-1:0]         out_dest;
  fu_set_t                   out_src;
  logic                      shr_empty;
  logic [NUM_READ_PORTS-1:0] raw_found;
  logic                      waw_found;
  logic                      lc_empty;

  // frontend issues only while ready
  assign accept = issue_i & write_i;

  result_shiftreg #(
    .DEST_W    (DEST_W),
    .NUM_STAGES(NUM_STAGES)
  ) u_shiftreg (
    .clk        (clk),
    .rst_i      (rst_i),
    .insert_i   (accept),
    .dest_i     (dest_i),
    .src_i      (fu_i),
    .latency_i  (latency_i),
    .occupied_o (occupied),
    .out_valid_o(out_valid),
    .out_dest_o (out_dest),
    .out_src_o  (out_src),
    .empty_o    (shr_empty)
  );

  // pending bit clears as the entry leaves stage 0
  lookup_cache #(
    .SIZE          (2 ** DEST_W),
    .NUM_TEST_PORTS(NUM_READ_PORTS)
  ) u_cache (
    .clk         (clk),
    .rst_i       (rst_i),
    .set_i       (accept),
    .set_addr_i  (dest_i),
    .clear_i     (out_valid),
    .clear_addr_i(out_dest),
    .test_addr_i (read_addr_i),
    .found_o     (raw_found),
    .waw_found_o (waw_found),
    .empty_o     (lc_empty)
  );

  // stall on slot collision, WAW, or RAW on an enabled port
  assign ready_o = ~((write_i & (occupied | waw_found)) | (|(raw_found & read_i)));

  assign empty_o = shr_empty & lc_empty;

  // disable masks the enable only, tracking still clears
  assign wb_we_o   = out_valid & ~disable_wb_i;
  assign wb_dest_o = out_dest;
  assign wb_src_o  = out_src;

endmodule

/* logic/result_shiftreg.sv */
// result shift register
// holds each in-flight write at the stage given by its latency and
// emits it from stage 0 to schedule the write-back

module result_shiftreg #(
  parameter int DEST_W     = 5,
  parameter int NUM_STAGES = 6
) (
  input  logic                     clk,
  input  logic                     rst_i,
  // new entry, inserted at stage latency-1
  input  logic                     insert_i,
  input  logic [DEST_W-1:0]        dest_i,
  input  inst_track_pkg::fu_set_t  src_i,
  input  inst_track_pkg::latency_t latency_i,
  // target stage already taken after the shift
  output logic                     occupied_o,
  // stage 0 output, drives the write-back
  output logic                     out_valid_o,
  output logic [DEST_W-1:0]        out_dest_o,
  output inst_track_pkg::fu_set_t  out_src_o,
  output logic                     empty_o
);

  import inst_track_pkg::*;

  logic [NUM_STAGES-1:0] valid_q;
  logic [NUM_STAGES-1:0] valid_d;
  // one-hot insertion stage for this cycle
  logic [NUM_STAGES-1:0] ins_stage;
  // payload per stage
  logic [DEST_W-1:0]     dest_q [NUM_STAGES];
  fu_set_t               src_q  [NUM_STAGES];

  // --------------------------------------
  // insertion and occupancy
  // --------------------------------------

  // latency L lands in stage L-1 on the issue edge
  always_comb begin
    ins_stage = '0;
    for (int s = 0; s < NUM_STAGES; s++) begin
      if (insert_i && (latency_i == latency_t'(s + 1))) begin
        ins_stage[s] = 1'b1;
      end
    end
  end

  // after the shift, stage L-1 holds what is in stage L now
  // latency NUM_STAGES targets the top stage, which is always free
  always_comb begin
    occupied_o = 1'b0;
    for (int s = 1; s < NUM_STAGES; s++) begin
      if (latency_i == latency_t'(s)) begin
        occupied_o = valid_q[s];
      end
    end
  end

  // --------------------------------------
  // shift toward stage 0
  // --------------------------------------

  // top stage fills with zero, new entry ORed in
  assign valid_d = (valid_q >> 1) | ins_stage;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // payload follows the valid bits
  for (genvar s = 0; s < NUM_STAGES; s++) begin : gen_stage
    if (s == NUM_STAGES - 1) begin : gen_top
      // top stage only ever loads new entries
      always_ff @(posedge clk) begin
        if (ins_stage[s]) begin
          dest_q[s] <= dest_i;
          src_q[s]  <= src_i;
        end
      end
    end else begin : gen_mid
      always_ff @(posedge clk) begin
        if (ins_stage[s]) begin
          dest_q[s] <= dest_i;
          src_q[s]  <= src_i;
        end else begin
          dest_q[s] <= dest_q[s+1];
          src_q[s]  <= src_q[s+1];
        end
      end
    end
  end

  // --------------------------------------
  // outputs
  // --------------------------------------

  assign out_valid_o = valid_q[0];
  assign out_dest_o  = dest_q[0];
  assign out_src_o   = src_q[0];

  assign empty_o = ~(|valid_q);

endmodule

/* src.f */
logic/inst_track_pkg.sv
logic/lookup_cache.sv
logic/result_shiftreg.sv
logic/reg_track.sv
logic/inst_track.sv
verif/inst_track_checker.sv
verif/tb_inst_track.sv

/* verif/inst_track_checker.sv */
// protocol checker for the issue-stage tracker
// bound to the top level, flags issue and write-back rule violations

module inst_track_checker (
  input logic                     clk,
  input logic                     rst_i,
  input logic                     issue_i,
  input logic                     gpr_write_i,
  input logic                     ctr_write_i,
  input inst_track_pkg::latency_t latency_i,
  input logic                     disable_wb_i,
  input logic                     ready_o,
  input logic                     pipe_empty_o,
  input logic                     gpr_wb_we_o,
  input logic                     ctr_wb_we_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import inst_track_pkg::*;

  // frontend holds a stalled instruction
  issue_needs_ready: assert property (@(posedge clk) disable iff (rst_i)
    issue_i |-> ready_o)
    else $error("issue raised while ready_o was low");

  // latency within the shift register depth of each class
  gpr_latency_range: assert property (@(posedge clk) disable iff (rst_i)
    issue_i && gpr_write_i |-> latency_i >= 1 && latency_i <= GPR_NUM_STAGES)
    else $error("gpr write issued with latency out of range");

  ctr_latency_range: assert property (@(posedge clk) disable iff (rst_i)
    issue_i && ctr_write_i |-> latency_i >= 1 && latency_i <= CTR_NUM_STAGES)
    else $error("ctr write issued with latency out of range");

  // enables are low from the first reset edge on
  no_wb_in_reset: assert property (@(posedge clk)
    $past(rst_i) |-> !gpr_wb_we_o && !ctr_wb_we_o)
    else $error("write-back enable high during reset");

  no_wb_when_disabled: assert property (@(posedge clk) disable iff (rst_i)
    disable_wb_i |-> !gpr_wb_we_o && !ctr_wb_we_o)
    else $error("write-back enable high while write-back is disabled");

  // a write-back means something is still in flight
  no_wb_when_empty: assert property (@(posedge clk) disable iff (rst_i)
    gpr_wb_we_o || ctr_wb_we_o |-> !pipe_empty_o)
    else $error("write-back enable high while the pipe reports empty");

endmodule

bind inst_track inst_track_checker u_checker (.*);

/* verif/inst_track_trace.txt */
// mk iss gw grd gd ra rb rt cw cr lat fu dis  rdy emp gwe gdst gsrc cwe csrc
// mk is 1 per cycle line, ff ends the trace, all fields hex
1 1 1 0 01 00 00 00 0 0 1 1 0  1 1 0 00 0 0 0
1 1 1 0 02 00 00 00 0 0 2 2 0  1 0 1 01 1 0 0
1 1 1 0 03 00 00 00 0 0 3 3 0  1 0 0 00 0 0 0
1 1 1 0 04 00 00 00 0 0 4 4 0  1 0 1 02 2 0 0
1 1 1 0 05 00 00 00 0 0 5 5 0  1 0 0 00 0 0 0
1 1 1 0 06 00 00 00 0 0 6 6 0  1 0 1 03 3 0 0
1 0 0 1 00 04 00 00 0 0 0 0 0  0 0 0 00 0 0 0
1 0 0 2 00 00 04 00 0 0 0 0 0  0 0 1 04 4 0 0
1 1 0 2 00 00 04 00 0 0 0 0 0  1 0 0 00 0 0 0
1 0 0 4 00 00 00 05 0 0 0 0 0  0 0 1 05 5 0 0
1 1 0 4 00 06 00 05 0 0 0 0 0  1 0 0 00 0 0 0
1 0 0 0 00 00 00 00 0 0 0 0 0  1 0 1 06 6 0 0
1 0 0 0 00 00 00 00 0 0 0 0 0  1 1 0 00 0 0 0
1 1 1 0 0a 00 00 00 0 0 4 2 0  1 1 0 00 0 0 0
1 0 1 0 0a 00 00 00 0 0 1 0 0  0 0 0 00 0 0 0
1 0 1 0 0b 00 00 00 0 0 2 0 0  0 0 0 00 0 0 0
1 1 1 0 0b 00 00 00 0 0 2 3 0  1 0 0 00 0 0 0
1 0 1 0 0a 00 00 00 0 0 3 1 0  0 0 1 0a 2 0 0
1 1 1 0 0a 00 00 00 0 0 3 1 0  1 0 1 0b 3 0 0
1 1 0 0 00 00 00 00 1 0 3 5 0  1 0 0 00 0 0 0
1 0 0 1 00 01 00 00 0 1 0 0 0  0 0 0 00 0 0 0
1 0 0 0 00 00 00 00 0 1 0 0 0  0 0 1 0a 1 0 0
1 0 0 0 00 00 00 00 0 1 0 0 0  0 0 0 00 0 1 5
1 1 0 0 00 00 00 00 0 1 0 0 0  1 1 0 00 0 0 0
1 1 0 0 00 00 00 00 1 0 1 6 0  1 1 0 00 0 0 0
1 0 0 0 00 00 00 00 1 0 2 7 0  0 0 0 00 0 1 6
1 1 0 0 00 00 00 00 1 0 2 7 0  1 1 0 00 0 0 0
1 1 1 1 0c 0a 00 00 0 0 1 4 0  1 0 0 00 0 0 0
1 0 0 0 00 00 00 00 0 0 0 0 0  1 0 1 0c 4 1 7
1 0 0 0 00 00 00 00 0 0 0 0 0  1 1 0 00 0 0 0
1 1 1 0 10 00 00 00 0 0 2 3 1  1 1 0 00 0 0 0
1 0 0 1 00 10 00 00 0 0 0 0 1  0 0 0 00 0 0 0
1 0 0 1 00 10 00 00 0 0 0 0 1  0 0 0 00 0 0 0
1 1 0 1 00 10 00 00 0 0 0 0 1  1 1 0 00 0 0 0
1 0 0 0 00 00 00 00 0 0 0 0 0  1 1 0 00 0 0 0
ff

/* verif/tb_inst_track.sv */
// testbench for the issue-stage dependency tracker
// replays a per-cycle trace of stimulus and expected outputs

module tb_inst_track;

  timeunit 1ns;
  timeprecision 100ps;

  import inst_track_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  // fields per trace line, and the most lines a trace may hold
  localparam int NUM_FIELDS   = 20;
  localparam int MAX_LINES    = 64;
  localparam logic [7:0] END_MARK = 8'hff;

  logic                          clk;
  logic                          rst_i;
  logic                          issue_i;
  latency_t                      latency_i;
  fu_set_t                       fu_i;
  logic                          disable_wb_i;
  logic                          gpr_write_i;
  gpr_idx_t                      gpr_dest_i;
  logic [GPR_NUM_READ_PORTS-1:0] gpr_read_i;
  gpr_idx_t                      gpr_ra_i;
  gpr_idx_t                      gpr_rb_i;
  gpr_idx_t                      gpr_rt_i;
  logic                          ctr_write_i;
  logic                          ctr_read_i;
  logic                          ready_o;
  logic                          pipe_empty_o;
  logic                          gpr_wb_we_o;
  gpr_idx_t                      gpr_wb_dest_o;
  fu_set_t                       gpr_wb_src_o;
  logic                          ctr_wb_we_o;
  fu_set_t                       ctr_wb_src_o;

  // flat trace, NUM_FIELDS bytes per cycle
  logic [7:0] trace_mem [NUM_FIELDS*MAX_LINES];
  int         error_count;
  int         check_count;

  inst_track u_dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // ----------------------------------------
  // trace helpers
  // ----------------------------------------

  // fields 1 to 12 are the stimulus
  task automatic apply_line(input int base);
    issue_i      = trace_mem[base + 1][0];
    gpr_write_i  = trace_mem[base + 2][0];
    gpr_read_i   = trace_mem[base + 3][2:0];
    gpr_dest_i   = trace_mem[base + 4][4:0];
    gpr_ra_i     = trace_mem[base + 5][4:0];
    gpr_rb_i     = trace_mem[base + 6][4:0];
    gpr_rt_i     = trace_mem[base + 7][4:0];
    ctr_write_i  = trace_mem[base + 8][0];
    ctr_read_i   = trace_mem[base + 9][0];
    latency_i    = trace_mem[base + 10][2:0];
    fu_i         = trace_mem[base + 11][2:0];
    disable_wb_i = trace_mem[base + 12][0];
  endtask

  task automatic compare(input string name, input int line,
                         input logic [7:0] exp_val, input logic [7:0] act_val);
    check_count++;
    assert (act_val === exp_val)
    else begin
      error_count++;
      $display("FAILED %s at cycle %0d: expected %0h, actual %0h",
               name, line, exp_val, act_val);
    end
  endtask

  // fields 13 to 19 are the expected outputs
  task automatic check_line(input int line);
    int base;
    base = line * NUM_FIELDS;
    compare("ready", line, trace_mem[base + 13], 8'(ready_o));
    compare("pipe_empty", line, trace_mem[base + 14], 8'(pipe_empty_o));
    compare("gpr_wb_we", line, trace_mem[base + 15], 8'(gpr_wb_we_o));
    compare("ctr_wb_we", line, trace_mem[base + 18], 8'(ctr_wb_we_o));
    // dest and src only mean something while the enable is high
    if (trace_mem[base + 15] == 8'h01) begin
      compare("gpr_wb_dest", line, trace_mem[base + 16], 8'(gpr_wb_dest_o));
      compare("gpr_wb_src", line, trace_mem[base + 17], 8'(gpr_wb_src_o));
    end
    if (trace_mem[base + 18] == 8'h01) begin
      compare("ctr_wb_src", line, trace_mem[base + 19], 8'(ctr_wb_src_o));
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    int line;
    bit done;
    error_count  = 0;
    check_count  = 0;
    line         = 0;
    done         = 1'b0;
    rst_i        = 1'b1;
    issue_i      = 1'b0;
    latency_i    = '0;
    fu_i         = '0;
    disable_wb_i = 1'b0;
    gpr_write_i  = 1'b0;
    gpr_dest_i   = '0;
    gpr_read_i   = '0;
    gpr_ra_i     = '0;
    gpr_rb_i     = '0;
    gpr_rt_i     = '0;
    ctr_write_i  = 1'b0;
    ctr_read_i   = 1'b0;
    $readmemh("verif/inst_track_trace.txt", trace_mem);
    repeat (RESET_CYCLES) @(negedge clk);
    rst_i = 1'b0;
    // one trace line per cycle, bounded by the trace size
    while (!done && line < MAX_LINES) begin
      if (trace_mem[line * NUM_FIELDS] === END_MARK) begin
        done = 1'b1;
      end else if (trace_mem[line * NUM_FIELDS] !== 8'h01) begin
        $display("trace line %0d has no valid marker, the trace is malformed", line);
        error_count++;
        done = 1'b1;
      end else begin
        apply_line(line * NUM_FIELDS);
        // sample just ahead of the rising edge, ready has settled by then
        #(CLK_PERIOD / 2 - 1);
        check_line(line);
        @(negedge clk);
        line++;
      end
    end
    if (!done) begin
      $display("timed out: no end marker within %0d trace lines", MAX_LINES);
      error_count++;
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
